/* Bender.yml */
package:
  name: runner

sources:
  - logic/runner_pkg.sv
  - logic/frame_tick.sv
  - logic/collision_check.sv
  - logic/game_fsm.sv
  - logic/speed_ramp.sv
  - logic/night_fade.sv
  - logic/life_hud.sv
  - logic/runner_top.sv
  - target: test
    files:
      - verif/runner_checker.sv
      - verif/runner_tb.sv

/* list.f */
logic/runner_pkg.sv
logic/frame_tick.sv
logic/collision_check.sv
logic/game_fsm.sv
logic/speed_ramp.sv
logic/night_fade.sv
logic/life_hud.sv
logic/runner_top.sv
verif/runner_checker.sv
verif/runner_tb.sv

/* logic/collision_check.sv */
module collision_check #(
    parameter int trex_boxes = 2,
    parameter int obstacle_boxes = 2
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [runner_pkg::coord_w-1:0] trex_box_x [trex_boxes],
    input  logic [runner_pkg::coord_w-1:0] trex_box_y [trex_boxes],
    input  logic [runner_pkg::coord_w-1:0] trex_box_w [trex_boxes],
    input  logic [runner_pkg::coord_w-1:0] trex_box_h [trex_boxes],
    input  logic [runner_pkg::coord_w-1:0] obstacle_box_x [obstacle_boxes],
    input  logic [runner_pkg::coord_w-1:0] obstacle_box_y [obstacle_boxes],
    input  logic [runner_pkg::coord_w-1:0] obstacle_box_w [obstacle_boxes],
    input  logic [runner_pkg::coord_w-1:0] obstacle_box_h [obstacle_boxes],
    output logic                           hit
);
    import runner_pkg::*;

    logic overlap;

    // One axis: each span starts before the other one ends
    function automatic logic spans_overlap(
        input logic [coord_w-1:0] a_pos,
        input logic [coord_w-1:0] a_len,
        input logic [coord_w-1:0] b_pos,
        input logic [coord_w-1:0] b_len
    );
        logic [coord_w:0] a_end;
        logic [coord_w:0] b_end;
        a_end = a_pos + a_len;
        b_end = b_pos + b_len;
        return (a_pos < b_end) && (b_pos < a_end);
    endfunction

    always_comb begin
        overlap = 1'b0;
        for (int i = 0; i < trex_boxes; i++) begin
            for (int j = 0; j < obstacle_boxes; j++) begin
                if (spans_overlap(trex_box_x[i], trex_box_w[i],
                                  obstacle_box_x[j], obstacle_box_w[j]) &&
                    spans_overlap(trex_box_y[i], trex_box_h[i],
                                  obstacle_box_y[j], obstacle_box_h[j])) begin
                    overlap = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit <= 1'b0;
        end else begin
            hit <= overlap;
        end
    end

endmodule

/* logic/frame_tick.sv */
module frame_tick #(
    parameter int fps = runner_pkg::default_fps,
    localparam int frame_w = (fps > 1) ? $clog2(fps) : 1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               painter_finished,
    output logic               update,
    output logic [frame_w-1:0] frame_count
);

    logic painter_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            painter_last <= 1'b0;
            update <= 1'b0;
            frame_count <= '0;
        end else begin
            painter_last <= painter_finished;
            // One game step per finished paint
            update <= painter_finished && !painter_last;

            if (update) begin
                if (frame_count == frame_w'(fps - 1)) begin
                    frame_count <= '0;
                end else begin
                    frame_count <= frame_count + 1'b1;
                end
            end
        end
    end

endmodule

/* logic/game_fsm.sv */
module game_fsm #(
    parameter int lives = runner_pkg::default_lives,
    parameter int restart_frames = runner_pkg::default_restart_frames
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          update,
    input  logic                          hit,
    input  logic                          jumping,
    output runner_pkg::state_t            state,
    output logic [runner_pkg::life_w-1:0] life,
    output logic                          restart,
    output logic                          start_pulse
);
    import runner_pkg::*;

    localparam int delay_w = $clog2(restart_frames + 1);

    logic hit_last;
    logic hit_pending;
    logic jumping_last;
    logic jump_edge;
    logic [delay_w-1:0] restart_timer;

    assign jump_edge = jumping && !jumping_last;
    assign start_pulse = (state == waiting) && update && jumping;
    assign restart = (state == restarting);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= waiting;
            life <= life_w'(lives);
            hit_last <= 1'b0;
            hit_pending <= 1'b0;
            jumping_last <= 1'b0;
            restart_timer <= '0;
        end else begin
            hit_last <= hit;
            jumping_last <= jumping;

            // A new overlap costs a life on the next game step
            if (update && hit_pending) begin
                hit_pending <= 1'b0;
            end
            if (hit && !hit_last && state == running) begin
                hit_pending <= 1'b1;
            end

            case (state)
                waiting: begin
                    if (start_pulse) begin
                        state <= running;
                    end
                end
                running: begin
                    if (update && hit_pending) begin
                        life <= life - 1'b1;
                        if (life == life_w'(1)) begin
                            state <= crashed;
                        end
                    end
                end
                crashed: begin
                    if (update && restart_timer < delay_w'(restart_frames)) begin
                        restart_timer <= restart_timer + 1'b1;
                    end
                    // Jump again to restart, only after the delay
                    if (restart_timer == delay_w'(restart_frames) && jump_edge) begin
                        state <= restarting;
                    end
                end
                restarting: begin
                    life <= life_w'(lives);
                    restart_timer <= '0;
                    hit_pending <= 1'b0;
                    if (!jumping) begin
                        state <= waiting;
                    end
                end
                default: state <= waiting;
            endcase
        end
    end

endmodule

/* logic/life_hud.sv */
module life_hud (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [runner_pkg::life_w-1:0]  life,
    output logic                           slot_visible [runner_pkg::hud_slots],
    output logic [runner_pkg::coord_w-1:0] slot_src_x [runner_pkg::hud_slots],
    output logic [runner_pkg::coord_w-1:0] slot_dst_x [runner_pkg::hud_slots]
);
    import runner_pkg::*;

    logic next_visible [hud_slots];
    logic [coord_w-1:0] next_src_x [hud_slots];
    logic [coord_w-1:0] next_dst_x [hud_slots];

    always_comb begin
        for (int i = 0; i < hud_slots; i++) begin
            next_visible[i] = 1'b0;
            next_src_x[i] = '0;
            next_dst_x[i] = '0;
        end

        if (life > hud_slots) begin
            // Icon, multiply sign and a single digit
            next_visible[0] = 1'b1;
            next_src_x[0] = coord_w'(life_src_x);
            next_dst_x[0] = coord_w'(life_x);

            next_visible[1] = 1'b1;
            next_src_x[1] = coord_w'(multiply_src_x);
            next_dst_x[1] = coord_w'(multiply_x);

            next_visible[2] = 1'b1;
            next_src_x[2] = coord_w'(digit_src_x + life * digit_src_w);
            next_dst_x[2] = coord_w'(life_num_x);
        end else begin
            // Few lives left, one icon each
            for (int i = 0; i < hud_slots; i++) begin
                if (i < life) begin
                    next_visible[i] = 1'b1;
                    next_src_x[i] = coord_w'(life_src_x);
                    next_dst_x[i] = coord_w'(life_x + i * life_w_px);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < hud_slots; i++) begin
                slot_visible[i] <= 1'b0;
            end
        end else begin
            slot_visible <= next_visible;
        end
    end

    always_ff @(posedge clk) begin
        slot_src_x <= next_src_x;
        slot_dst_x <= next_dst_x;
    end

endmodule

/* logic/night_fade.sv */
module night_fade #(
    parameter int fade_frames = runner_pkg::default_fade_frames
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          update,
    input  logic                          restart,
    input  runner_pkg::state_t            state,
    input  logic                          invert_trigger,
    output logic [runner_pkg::rate_w-1:0] night_rate
);
    import runner_pkg::*;

    localparam int fade_w = $clog2(fade_frames + 1);

    logic inverted;
    logic [fade_w-1:0] fade_timer;

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            inverted <= 1'b0;
            fade_timer <= '0;
            night_rate <= '0;
        end else begin
            if (state == running && !inverted && invert_trigger) begin
                inverted <= 1'b1;
            end else if (update && state == running && inverted) begin
                // Night lasts a fixed number of running frames
                if (fade_timer == fade_w'(fade_frames - 1)) begin
                    inverted <= 1'b0;
                    fade_timer <= '0;
                end else begin
                    fade_timer <= fade_timer + 1'b1;
                end
            end

            if (update) begin
                if (inverted && night_rate < rate_w'(max_night_rate)) begin
                    night_rate <= night_rate + 1'b1;
                end else if (!inverted && night_rate != '0) begin
                    night_rate <= night_rate - 1'b1;
                end
            end
        end
    end

endmodule

/* logic/runner_pkg.sv */
package runner_pkg;

    typedef enum logic [1:0] {
        waiting,
        running,
        crashed,
        restarting
    } state_t;

    localparam int coord_w = 12;
    localparam int speed_w = 15;
    localparam int life_w = 4;
    localparam int rate_w = 6;

    // Rectangle on the sprite sheet or on screen
    typedef struct packed {
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
        logic [coord_w-1:0] w;
        logic [coord_w-1:0] h;
    } sprite_t;

    // Game speed is held in 1/1024 of a pixel per frame
    localparam int speed_scale = 1024;

    localparam int start_speed = 6 * speed_scale;
    localparam int slow_start_speed = 4 * speed_scale;

    localparam int max_speed = 13 * speed_scale;
    localparam int slow_max_speed = 9 * speed_scale;

    localparam int acceleration = 1;

    localparam int max_night_rate = 63;

    // Lives part of the HUD
    localparam int hud_slots = 5;

    localparam int life_src_x = 1540;
    localparam int multiply_src_x = 1571;
    localparam int digit_src_x = 1294;
    localparam int digit_src_w = 20;

    localparam int life_x = 22;
    localparam int life_w_px = 31;
    localparam int multiply_x = 53;
    localparam int life_num_x = 75;

    localparam int default_fps = 60;
    localparam int default_lives = 9;
    localparam int default_clear_frames = 180;
    localparam int default_restart_frames = 60;
    localparam int default_fade_frames = 720;

endpackage

/* logic/runner_top.sv */
module runner_top #(
    parameter int fps = runner_pkg::default_fps,
    parameter int lives = runner_pkg::default_lives,
    parameter int clear_frames = runner_pkg::default_clear_frames,
    parameter int restart_frames = runner_pkg::default_restart_frames,
    parameter int fade_frames = runner_pkg::default_fade_frames,
    parameter int trex_boxes = 2,
    parameter int obstacle_boxes = 2
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           slow,
    input  logic                           jumping,
    input  logic                           painter_finished,
    input  logic                           invert_trigger,
    input  logic [runner_pkg::coord_w-1:0] trex_box_x [trex_boxes],
    input  logic [runner_pkg::coord_w-1:0] trex_box_y [trex_boxes],
    input  logic [runner_pkg::coord_w-1:0] trex_box_w [trex_boxes],
    input  logic [runner_pkg::coord_w-1:0] trex_box_h [trex_boxes],
    input  logic [runner_pkg::coord_w-1:0] obstacle_box_x [obstacle_boxes],
    input  logic [runner_pkg::coord_w-1:0] obstacle_box_y [obstacle_boxes],
    input  logic [runner_pkg::coord_w-1:0] obstacle_box_w [obstacle_boxes],
    input  logic [runner_pkg::coord_w-1:0] obstacle_box_h [obstacle_boxes],
    output runner_pkg::state_t             game_state,
    output logic [runner_pkg::speed_w-1:0] speed,
    output logic                           has_obstacles,
    output logic [runner_pkg::life_w-1:0]  life,
    output logic [runner_pkg::rate_w-1:0]  night_rate,
    output logic                           slot_visible [runner_pkg::hud_slots],
    output logic [runner_pkg::coord_w-1:0] slot_src_x [runner_pkg::hud_slots],
    output logic [runner_pkg::coord_w-1:0] slot_dst_x [runner_pkg::hud_slots]
);

    localparam int frame_w = (fps > 1) ? $clog2(fps) : 1;

    logic update;
    logic [frame_w-1:0] frame_count;
    logic hit;
    logic restart;
    logic start_pulse;

    frame_tick #(
        .fps(fps)
    ) u_frame_tick (
        .clk(clk),
        .rst(rst),
        .painter_finished(painter_finished),
        .update(update),
        .frame_count(frame_count)
    );

    collision_check #(
        .trex_boxes(trex_boxes),
        .obstacle_boxes(obstacle_boxes)
    ) u_collision_check (
        .clk(clk),
        .rst(rst),
        .trex_box_x(trex_box_x),
        .trex_box_y(trex_box_y),
        .trex_box_w(trex_box_w),
        .trex_box_h(trex_box_h),
        .obstacle_box_x(obstacle_box_x),
        .obstacle_box_y(obstacle_box_y),
        .obstacle_box_w(obstacle_box_w),
        .obstacle_box_h(obstacle_box_h),
        .hit(hit)
    );

    game_fsm #(
        .lives(lives),
        .restart_frames(restart_frames)
    ) u_game_fsm (
        .clk(clk),
        .rst(rst),
        .update(update),
        .hit(hit),
        .jumping(jumping),
        .state(game_state),
        .life(life),
        .restart(restart),
        .start_pulse(start_pulse)
    );

    speed_ramp #(
        .fps(fps),
        .clear_frames(clear_frames)
    ) u_speed_ramp (
        .clk(clk),
        .rst(rst),
        .update(update),
        .start_pulse(start_pulse),
        .restart(restart),
        .state(game_state),
        .slow(slow),
        .frame_count(frame_count),
        .speed(speed),
        .has_obstacles(has_obstacles)
    );

    night_fade #(
        .fade_frames(fade_frames)
    ) u_night_fade (
        .clk(clk),
        .rst(rst),
        .update(update),
        .restart(restart),
        .state(game_state),
        .invert_trigger(invert_trigger),
        .night_rate(night_rate)
    );

    life_hud u_life_hud (
        .clk(clk),
        .rst(rst),
        .life(life),
        .slot_visible(slot_visible),
        .slot_src_x(slot_src_x),
        .slot_dst_x(slot_dst_x)
    );

endmodule

/* logic/speed_ramp.sv */
module speed_ramp #(
    parameter int fps = runner_pkg::default_fps,
    parameter int clear_frames = runner_pkg::default_clear_frames,
    localparam int frame_w = (fps > 1) ? $clog2(fps) : 1
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           update,
    input  logic                           start_pulse,
    input  logic                           restart,
    input  runner_pkg::state_t             state,
    input  logic                           slow,
    input  logic [frame_w-1:0]             frame_count,
    output logic [runner_pkg::speed_w-1:0] speed,
    output logic                           has_obstacles
);
    import runner_pkg::*;

    localparam int clear_w = $clog2(clear_frames + 1);

    logic [clear_w-1:0] clear_timer;
    logic [speed_w-1:0] speed_cap;
    logic step_ok;

    always_comb begin
        speed_cap = slow ? speed_w'(slow_max_speed) : speed_w'(max_speed);
        // Half the acceleration in slow mode
        step_ok = !slow || !frame_count[0];
    end

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            speed <= '0;
            clear_timer <= '0;
            has_obstacles <= 1'b0;
        end else if (start_pulse) begin
            speed <= slow ? speed_w'(slow_start_speed) : speed_w'(start_speed);
        end else if (update && state == running) begin
            if (step_ok && speed + acceleration <= speed_cap) begin
                speed <= speed + speed_w'(acceleration);
            end

            // Keep the track empty for the first frames
            if (!has_obstacles) begin
                if (clear_timer == clear_w'(clear_frames - 1)) begin
                    has_obstacles <= 1'b1;
                end else begin
                    clear_timer <= clear_timer + 1'b1;
                end
            end
        end
    end

endmodule

/* verif/runner_checker.sv */
module runner_checker (
    input logic                          clk,
    input logic                          rst,
    input logic                          update,
    input logic [runner_pkg::life_w-1:0] life,
    input logic                          restart,
    input runner_pkg::state_t            state
);
    timeunit 1ns;
    timeprecision 100ps;

    import runner_pkg::*;

    int failures = 0;

    assert property (@(posedge clk) disable iff (rst) update |=> !update)
        else begin
            failures++;
            $error("update was high for two cycles in a row");
        end

    // Lives are only refilled by the restart state
    assert property (@(posedge clk) disable iff (rst) (life > $past(life)) |-> $past(restart))
        else begin
            failures++;
            $error("life rose without a restart");
        end

    // Restarting is only reached through a crash
    assert property (@(posedge clk) disable iff (rst)
                     restart |-> $past(state) inside {crashed, restarting})
        else begin
            failures++;
            $error("restart was high without a crash before it");
        end

endmodule

/* verif/runner_tb.sv */
module runner_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import runner_pkg::*;

    localparam int clk_period = 8;
    localparam int tb_fps = 4;
    localparam int tb_lives = 3;
    localparam int many_lives = 9;
    localparam int fade_len = 4;
    // Roughly 30 frames of 5 cycles and six resets, with a wide margin
    localparam int test_cycles = 40 * 5 + 6 * 8 + 40;
    localparam int watchdog_ns = 2 * test_cycles * clk_period;

    logic clk;
    logic rst;
    logic slow;
    logic jumping;
    logic painter_finished;
    logic invert_trigger;
    logic [coord_w-1:0] trex_box_x [2];
    logic [coord_w-1:0] trex_box_y [2];
    logic [coord_w-1:0] trex_box_w [2];
    logic [coord_w-1:0] trex_box_h [2];
    logic [coord_w-1:0] obstacle_box_x [2];
    logic [coord_w-1:0] obstacle_box_y [2];
    logic [coord_w-1:0] obstacle_box_w [2];
    logic [coord_w-1:0] obstacle_box_h [2];
    state_t game_state;
    logic [speed_w-1:0] speed;
    logic has_obstacles;
    logic [life_w-1:0] life;
    logic [rate_w-1:0] night_rate;
    logic slot_visible [hud_slots];
    logic [coord_w-1:0] slot_src_x [hud_slots];
    logic [coord_w-1:0] slot_dst_x [hud_slots];
    logic [life_w-1:0] many_life;
    logic many_visible [hud_slots];
    logic [coord_w-1:0] many_src_x [hud_slots];
    logic [coord_w-1:0] many_dst_x [hud_slots];

    int checks = 0;
    int errors = 0;
    int frame_no = 0;

    runner_top #(
        .fps(tb_fps),
        .lives(tb_lives),
        .clear_frames(3),
        .restart_frames(2),
        .fade_frames(fade_len)
    ) UUT (
        .clk(clk),
        .rst(rst),
        .slow(slow),
        .jumping(jumping),
        .painter_finished(painter_finished),
        .invert_trigger(invert_trigger),
        .trex_box_x(trex_box_x),
        .trex_box_y(trex_box_y),
        .trex_box_w(trex_box_w),
        .trex_box_h(trex_box_h),
        .obstacle_box_x(obstacle_box_x),
        .obstacle_box_y(obstacle_box_y),
        .obstacle_box_w(obstacle_box_w),
        .obstacle_box_h(obstacle_box_h),
        .game_state(game_state),
        .speed(speed),
        .has_obstacles(has_obstacles),
        .life(life),
        .night_rate(night_rate),
        .slot_visible(slot_visible),
        .slot_src_x(slot_src_x),
        .slot_dst_x(slot_dst_x)
    );

    // Second copy with many lives for the icon, multiply and digit layout
    runner_top #(
        .fps(tb_fps),
        .lives(many_lives),
        .clear_frames(3),
        .restart_frames(2),
        .fade_frames(fade_len)
    ) hud_dut (
        .clk(clk),
        .rst(rst),
        .slow(slow),
        .jumping(jumping),
        .painter_finished(painter_finished),
        .invert_trigger(invert_trigger),
        .trex_box_x(trex_box_x),
        .trex_box_y(trex_box_y),
        .trex_box_w(trex_box_w),
        .trex_box_h(trex_box_h),
        .obstacle_box_x(obstacle_box_x),
        .obstacle_box_y(obstacle_box_y),
        .obstacle_box_w(obstacle_box_w),
        .obstacle_box_h(obstacle_box_h),
        .game_state(),
        .speed(),
        .has_obstacles(),
        .life(many_life),
        .night_rate(),
        .slot_visible(many_visible),
        .slot_src_x(many_src_x),
        .slot_dst_x(many_dst_x)
    );

    bind game_fsm runner_checker u_checker (
        .clk(clk),
        .rst(rst),
        .update(update),
        .life(life),
        .restart(restart),
        .state(state)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_value(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Obstacle 0 is moved onto the first T-Rex box or parked far away
    task automatic set_overlap(input logic on);
        obstacle_box_x[0] = on ? coord_w'(20) : coord_w'(500);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        jumping = 1'b0;
        painter_finished = 1'b0;
        invert_trigger = 1'b0;
        set_overlap(1'b0);
        repeat (4) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        frame_no = 0;
    endtask

    // One painter pulse, then wait for the game step and the HUD register
    task automatic run_frame();
        @(negedge clk);
        painter_finished = 1'b1;
        @(negedge clk);
        while (!UUT.update) @(negedge clk);
        painter_finished = 1'b0;
        repeat (2) @(negedge clk);
        frame_no = (frame_no + 1) % tb_fps;
    endtask

    task automatic start_game();
        jumping = 1'b1;
        run_frame();
        jumping = 1'b0;
    endtask

    task automatic pulse_overlap();
        set_overlap(1'b1);
        @(negedge clk);
        set_overlap(1'b0);
        @(negedge clk);
    endtask

    task automatic check_hud_slot(input string who, input int lives_now, input int idx,
                                  input logic vis, input int src, input int dst);
        logic exp_vis;
        int exp_src;
        int exp_dst;
        exp_vis = 1'b0;
        exp_src = life_src_x;
        exp_dst = life_x + idx * life_w_px;
        if (lives_now > hud_slots) begin
            exp_vis = (idx < 3);
            if (idx == 0) begin
                exp_dst = life_x;
            end else if (idx == 1) begin
                exp_src = multiply_src_x;
                exp_dst = multiply_x;
            end else begin
                exp_src = digit_src_x + lives_now * digit_src_w;
                exp_dst = life_num_x;
            end
        end else begin
            exp_vis = (idx < lives_now);
        end
        check_value($sformatf("%s slot %0d visible", who, idx), vis, exp_vis);
        if (exp_vis) begin
            check_value($sformatf("%s slot %0d source x", who, idx), src, exp_src);
            check_value($sformatf("%s slot %0d screen x", who, idx), dst, exp_dst);
        end
    endtask

    task automatic check_hud(input int uut_lives, input int second_lives);
        for (int i = 0; i < hud_slots; i++) begin
            check_hud_slot("uut", uut_lives, i, slot_visible[i], slot_src_x[i], slot_dst_x[i]);
            check_hud_slot("hud_dut", second_lives, i, many_visible[i], many_src_x[i],
                           many_dst_x[i]);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset();
        int errors_before;
        errors_before = errors;
        apply_reset();
        check_value("state", int'(game_state), int'(waiting));
        check_value("life", life, tb_lives);
        check_value("speed", speed, 0);
        check_value("night_rate", night_rate, 0);
        check_value("has_obstacles", has_obstacles, 0);
        report_test("reset", errors_before);
    endtask

    task automatic test_start();
        int errors_before;
        errors_before = errors;
        start_game();
        check_value("state", int'(game_state), int'(running));
        check_value("speed", speed, start_speed);
        apply_reset();
        slow = 1'b1;
        start_game();
        check_value("state", int'(game_state), int'(running));
        check_value("slow speed", speed, slow_start_speed);
        report_test("start", errors_before);
    endtask

    task automatic test_ramp();
        int errors_before;
        int exp_speed;
        errors_before = errors;
        // Slow mode steps only on even frame numbers
        exp_speed = slow_start_speed;
        for (int k = 0; k < 5; k++) begin
            if (frame_no % 2 == 0) begin
                exp_speed = exp_speed + acceleration;
            end
            run_frame();
            check_value("slow speed", speed, exp_speed);
        end
        apply_reset();
        slow = 1'b0;
        start_game();
        for (int k = 1; k <= 3; k++) begin
            run_frame();
            check_value("speed", speed, start_speed + k * acceleration);
            check_value("has_obstacles", has_obstacles, k >= 3);
        end
        report_test("ramp", errors_before);
    endtask

    task automatic test_collision();
        int errors_before;
        errors_before = errors;
        apply_reset();
        start_game();
        check_hud(tb_lives, many_lives);
        pulse_overlap();
        run_frame();
        check_value("life", life, tb_lives - 1);
        check_value("hud_dut life", many_life, many_lives - 1);
        check_hud(tb_lives - 1, many_lives - 1);
        // A held overlap is a single new hit
        set_overlap(1'b1);
        run_frame();
        run_frame();
        set_overlap(1'b0);
        @(negedge clk);
        check_value("life", life, tb_lives - 2);
        check_value("hud_dut life", many_life, many_lives - 2);
        check_hud(tb_lives - 2, many_lives - 2);
        report_test("collision", errors_before);
    endtask

    task automatic test_restart();
        int errors_before;
        errors_before = errors;
        pulse_overlap();
        run_frame();
        check_value("life", life, 0);
        check_value("state", int'(game_state), int'(crashed));
        run_frame();
        jumping = 1'b1;
        @(negedge clk);
        jumping = 1'b0;
        @(negedge clk);
        check_value("state after early jump", int'(game_state), int'(crashed));
        run_frame();
        jumping = 1'b1;
        @(negedge clk);
        check_value("state after jump", int'(game_state), int'(restarting));
        jumping = 1'b0;
        while (game_state != waiting) @(negedge clk);
        @(negedge clk);
        check_value("life", life, tb_lives);
        check_value("speed", speed, 0);
        report_test("restart", errors_before);
    endtask

    task automatic test_night();
        int errors_before;
        errors_before = errors;
        apply_reset();
        start_game();
        invert_trigger = 1'b1;
        @(negedge clk);
        invert_trigger = 1'b0;
        for (int k = 1; k <= fade_len; k++) begin
            run_frame();
            check_value("night_rate rising", night_rate, k);
        end
        for (int k = fade_len - 1; k >= 0; k--) begin
            run_frame();
            check_value("night_rate falling", night_rate, k);
        end
        run_frame();
        check_value("night_rate at rest", night_rate, 0);
        report_test("night", errors_before);
    endtask

    initial begin
        int assert_failures;
        rst = 1'b1;
        slow = 1'b0;
        jumping = 1'b0;
        painter_finished = 1'b0;
        invert_trigger = 1'b0;
        trex_box_x = '{coord_w'(10), coord_w'(15)};
        trex_box_y = '{coord_w'(50), coord_w'(20)};
        trex_box_w = '{coord_w'(20), coord_w'(10)};
        trex_box_h = '{coord_w'(30), coord_w'(30)};
        obstacle_box_x = '{coord_w'(500), coord_w'(600)};
        obstacle_box_y = '{coord_w'(50), coord_w'(50)};
        obstacle_box_w = '{coord_w'(15), coord_w'(15)};
        obstacle_box_h = '{coord_w'(30), coord_w'(30)};

        test_reset();
        test_start();
        test_ramp();
        test_collision();
        test_restart();
        test_night();

        assert_failures = UUT.u_game_fsm.u_checker.failures +
                          hud_dut.u_game_fsm.u_checker.failures;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, assert_failures);
        if (errors == 0 && assert_failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
